// File: hw/lcd_config.svh
`ifndef LCD_CONFIG_SVH
`define LCD_CONFIG_SVH

// panel geometry
`define LCD_NUM_LINES 2
`define LCD_LINE_LEN 16

// bus timing in clock cycles is kept short so the simulation stays fast
`define LCD_SETUP_CYCLES 2
`define LCD_EN_CYCLES 4
`define LCD_WAIT_CYCLES 8

// a clear command needs a much longer wait before the next byte
`define LCD_CLEAR_WAIT_CYCLES 40

`endif

// File: hw/lcd_pkg.sv
`include "lcd_config.svh"

package lcd_pkg;

    typedef logic [7:0] char_t;

    typedef enum logic [1:0] {
        ST_INIT,
        ST_IDLE,
        ST_ADDRESS,
        ST_CHAR
    } ctrl_state_t;

    ////////////////////////////////////////
    // panel commands
    ////////////////////////////////////////

    // 8-bit bus, two lines, 5x8 font
    localparam char_t CMD_FUNCTION_SET = 8'h38;
    // display on, cursor and blink off
    localparam char_t CMD_DISPLAY_ON   = 8'h0C;
    localparam char_t CMD_CLEAR        = 8'h01;
    // increment the address, no shift
    localparam char_t CMD_ENTRY_MODE   = 8'h06;
    localparam char_t CMD_SET_DDRAM    = 8'h80;

    localparam int    INIT_LEN = 4;
    localparam char_t INIT_SEQ [INIT_LEN] = '{
        CMD_FUNCTION_SET, CMD_DISPLAY_ON, CMD_CLEAR, CMD_ENTRY_MODE
    };

    // DDRAM start address of each display line
    localparam char_t LINE_BASE [`LCD_NUM_LINES] = '{8'h00, 8'h40};

    localparam char_t CHAR_SPACE = 8'h20;

endpackage

// File: hw/lcd_wb_regs.sv
`include "lcd_config.svh"

module lcd_wb_regs (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      wb_cyc,
    input  logic                      wb_stb,
    input  logic                      wb_we,
    input  logic [5:0]                wb_adr,
    input  lcd_pkg::char_t            wb_dat_w,
    input  logic                      init_done,
    input  lcd_pkg::char_t            rd_char_all [`LCD_NUM_LINES],
    output lcd_pkg::char_t            wb_dat_r,
    output logic                      wb_ack,
    output logic [`LCD_NUM_LINES-1:0] wr_en,
    output logic [3:0]                wr_col,
    output lcd_pkg::char_t            wr_char,
    output logic [3:0]                host_col,
    output logic                      lcd_on,
    output logic                      lcd_blon
);
    import lcd_pkg::*;

    logic       req;
    logic       ack_hold;
    logic       wr_acc;
    logic [1:0] ctrl_q;

    assign req    = wb_cyc && wb_stb;
    assign wr_acc = wb_ack && req && wb_we;

    ////////////////////////////////////////
    // single-cycle acknowledge
    ////////////////////////////////////////

    // ack_hold blocks a second ack while the master keeps stb high
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb_ack   <= 1'b0;
            ack_hold <= 1'b0;
        end else begin
            wb_ack   <= req && !wb_ack && !ack_hold;
            ack_hold <= wb_stb && (ack_hold || wb_ack);
        end
    end

    // character writes land in the acknowledge cycle and bit 4 picks the line
    always_comb begin
        wr_en = '0;
        for (int i = 0; i < `LCD_NUM_LINES; i++) begin
            if (wr_acc && !wb_adr[5] && (int'(wb_adr[4]) == i))
                wr_en[i] = 1'b1;
        end
    end

    assign wr_col   = wb_adr[3:0];
    assign wr_char  = wb_dat_w;
    assign host_col = wb_adr[3:0];

    always_ff @(posedge clk) begin
        if (!rstN)
            ctrl_q <= 2'b00;
        else if (wr_acc && wb_adr == 6'h20)
            ctrl_q <= wb_dat_w[1:0];
    end

    assign lcd_on   = ctrl_q[0];
    assign lcd_blon = ctrl_q[1];

    // read data is sampled on the edge that raises ack
    always_ff @(posedge clk) begin
        if (req && !wb_ack && !ack_hold) begin
            if (!wb_adr[5])
                wb_dat_r <= rd_char_all[wb_adr[4]];
            else if (wb_adr == 6'h20)
                wb_dat_r <= char_t'({6'b0, ctrl_q});
            else if (wb_adr == 6'h21)
                wb_dat_r <= char_t'({7'b0, init_done});
            else
                wb_dat_r <= '0;
        end
    end

endmodule

// File: hw/lcd_line_buffer.sv
`include "lcd_config.svh"

module lcd_line_buffer (
    input  logic           clk,
    input  logic           rstN,
    input  logic           wr_en,
    input  logic [3:0]     wr_col,
    input  lcd_pkg::char_t wr_char,
    input  logic [3:0]     host_col,
    input  logic [3:0]     rd_col,
    input  logic           take,
    output lcd_pkg::char_t host_char,
    output lcd_pkg::char_t rd_char,
    output logic           dirty
);
    import lcd_pkg::*;

    char_t mem [`LCD_LINE_LEN];

    // the line comes out of reset blank, so the first refresh clears the panel
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `LCD_LINE_LEN; i++)
                mem[i] <= CHAR_SPACE;
        end else if (wr_en) begin
            mem[wr_col] <= wr_char;
        end
    end

    // a write in the same cycle as take keeps the line dirty
    always_ff @(posedge clk) begin
        if (!rstN)
            dirty <= 1'b1;
        else if (wr_en)
            dirty <= 1'b1;
        else if (take)
            dirty <= 1'b0;
    end

    assign host_char = mem[host_col];
    assign rd_char   = mem[rd_col];

endmodule

// File: hw/lcd_refresh_ctrl.sv
`include "lcd_config.svh"

module lcd_refresh_ctrl (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`LCD_NUM_LINES-1:0] dirty,
    input  lcd_pkg::char_t            rd_char_all [`LCD_NUM_LINES],
    input  logic                      busy,
    output logic [`LCD_NUM_LINES-1:0] take,
    output logic [3:0]                rd_col,
    output logic                      start,
    output logic                      rs,
    output lcd_pkg::char_t            tx_byte,
    output logic                      long_wait,
    output logic                      init_done
);
    import lcd_pkg::*;

    localparam int LINE_W = (`LCD_NUM_LINES > 1) ? $clog2(`LCD_NUM_LINES) : 1;

    ctrl_state_t       state;
    logic [3:0]        idx;
    logic [LINE_W-1:0] line;
    logic [LINE_W-1:0] pick;
    logic              accept;

    // lowest-numbered dirty line wins
    always_comb begin
        pick = '0;
        for (int i = `LCD_NUM_LINES - 1; i >= 0; i--) begin
            if (dirty[i])
                pick = LINE_W'(i);
        end
    end

    ////////////////////////////////////////
    // byte selection toward the bus driver
    ////////////////////////////////////////

    always_comb begin
        start     = 1'b0;
        rs        = 1'b0;
        tx_byte   = '0;
        long_wait = 1'b0;
        take      = '0;
        case (state)
            ST_INIT: begin
                if (idx < 4'(INIT_LEN)) begin
                    start     = !busy;
                    tx_byte   = INIT_SEQ[idx[1:0]];
                    long_wait = (INIT_SEQ[idx[1:0]] == CMD_CLEAR);
                end
            end
            ST_IDLE: begin
                if (|dirty)
                    take[pick] = 1'b1;
            end
            ST_ADDRESS: begin
                start   = !busy;
                tx_byte = CMD_SET_DDRAM | LINE_BASE[line];
            end
            ST_CHAR: begin
                start   = !busy;
                rs      = 1'b1;
                tx_byte = rd_char_all[line];
            end
            default: begin
                start = 1'b0;
            end
        endcase
    end

    assign accept = start && !busy;
    assign rd_col = idx;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= ST_INIT;
            idx       <= '0;
            line      <= '0;
            init_done <= 1'b0;
        end else begin
            case (state)
                ST_INIT: begin
                    if (accept)
                        idx <= idx + 4'd1;
                    // done once the last command has finished its wait
                    if (idx == 4'(INIT_LEN) && !busy) begin
                        init_done <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (|dirty) begin
                        line  <= pick;
                        state <= ST_ADDRESS;
                    end
                end
                ST_ADDRESS: begin
                    if (accept) begin
                        idx   <= '0;
                        state <= ST_CHAR;
                    end
                end
                ST_CHAR: begin
                    if (accept) begin
                        if (idx == 4'(`LCD_LINE_LEN - 1))
                            state <= ST_IDLE;
                        else
                            idx <= idx + 4'd1;
                    end
                end
                default: state <= ST_INIT;
            endcase
        end
    end

endmodule

// File: hw/lcd_bus_driver.sv
`include "lcd_config.svh"

module lcd_bus_driver (
    input  logic           clk,
    input  logic           rstN,
    input  logic           start,
    input  logic           rs,
    input  lcd_pkg::char_t tx_byte,
    input  logic           long_wait,
    output logic           busy,
    output logic           lcd_rs,
    output lcd_pkg::char_t lcd_data,
    output logic           lcd_en
);
    import lcd_pkg::*;

    localparam int CNT_W = $clog2(`LCD_CLEAR_WAIT_CYCLES + 1);

    typedef enum logic [1:0] {PH_IDLE, PH_SETUP, PH_ENABLE, PH_WAIT} phase_t;

    phase_t           phase;
    logic [CNT_W-1:0] cnt;
    logic             long_q;
    logic             accept;

    assign busy   = (phase != PH_IDLE);
    assign accept = start && !busy;

    // rs and data stay put from accept until the driver is free again
    always_ff @(posedge clk) begin
        if (accept) begin
            lcd_data <= tx_byte;
            long_q   <= long_wait;
        end
    end

    ////////////////////////////////////////
    // setup, enable pulse, wait
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase  <= PH_IDLE;
            cnt    <= '0;
            lcd_en <= 1'b0;
            lcd_rs <= 1'b0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (accept) begin
                        lcd_rs <= rs;
                        cnt    <= CNT_W'(`LCD_SETUP_CYCLES - 1);
                        phase  <= PH_SETUP;
                    end
                end
                PH_SETUP: begin
                    if (cnt == '0) begin
                        lcd_en <= 1'b1;
                        cnt    <= CNT_W'(`LCD_EN_CYCLES - 1);
                        phase  <= PH_ENABLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PH_ENABLE: begin
                    if (cnt == '0) begin
                        // the panel latches on this falling edge
                        lcd_en <= 1'b0;
                        cnt    <= long_q ? CNT_W'(`LCD_CLEAR_WAIT_CYCLES - 1)
                                         : CNT_W'(`LCD_WAIT_CYCLES - 1);
                        phase  <= PH_WAIT;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                PH_WAIT: begin
                    if (cnt == '0)
                        phase <= PH_IDLE;
                    else
                        cnt <= cnt - 1'b1;
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

// File: hw/lcd_subsystem.sv
`include "lcd_config.svh"

module lcd_subsystem (
    input  logic           clk,
    input  logic           rstN,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  logic [5:0]     wb_adr,
    input  lcd_pkg::char_t wb_dat_w,
    output lcd_pkg::char_t wb_dat_r,
    output logic           wb_ack,
    output lcd_pkg::char_t lcd_data,
    output logic           lcd_rs,
    output logic           lcd_en,
    output logic           lcd_rw,
    output logic           lcd_on,
    output logic           lcd_blon
);
    import lcd_pkg::*;

    logic [`LCD_NUM_LINES-1:0] wr_en;
    logic [3:0]                wr_col;
    char_t                     wr_char;
    logic [3:0]                host_col;
    char_t                     host_char_all [`LCD_NUM_LINES];
    char_t                     rd_char_all [`LCD_NUM_LINES];
    logic [`LCD_NUM_LINES-1:0] dirty;
    logic [`LCD_NUM_LINES-1:0] take;
    logic [3:0]                rd_col;
    logic                      start;
    logic                      rs;
    char_t                     tx_byte;
    logic                      long_wait;
    logic                      busy;
    logic                      init_done;

    // the panel is never read back
    assign lcd_rw = 1'b0;

    lcd_wb_regs u_regs (
        .clk, .rstN, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .init_done,
        .rd_char_all(host_char_all), .wb_dat_r, .wb_ack, .wr_en, .wr_col, .wr_char,
        .host_col, .lcd_on, .lcd_blon
    );

    for (genvar g = 0; g < `LCD_NUM_LINES; g++) begin : g_line
        lcd_line_buffer u_buf (
            .clk, .rstN, .wr_en(wr_en[g]), .wr_col, .wr_char, .host_col, .rd_col,
            .take(take[g]), .host_char(host_char_all[g]), .rd_char(rd_char_all[g]),
            .dirty(dirty[g])
        );
    end

    lcd_refresh_ctrl u_ctrl (
        .clk, .rstN, .dirty, .rd_char_all, .busy, .take, .rd_col, .start, .rs,
        .tx_byte, .long_wait, .init_done
    );

    lcd_bus_driver u_drv (
        .clk, .rstN, .start, .rs, .tx_byte, .long_wait, .busy, .lcd_rs, .lcd_data,
        .lcd_en
    );

endmodule

// File: testbench/lcd_panel_model.sv
`include "lcd_config.svh"

module lcd_panel_model (
    input logic           clk,
    input lcd_pkg::char_t lcd_data,
    input logic           lcd_rs,
    input logic           lcd_en
);
    import lcd_pkg::*;

    localparam int LOG_DEPTH = 512;

    char_t      image [`LCD_NUM_LINES][`LCD_LINE_LEN];
    logic       log_rs [LOG_DEPTH];
    char_t      log_data [LOG_DEPTH];
    int         log_width [LOG_DEPTH];
    int         byte_count = 0;
    int         unstable_count = 0;
    int         en_cycles = 0;
    logic       pulse_open = 1'b0;
    logic [6:0] addr = '0;

    // the image starts as zeros so that only a clear or a refresh fills it
    initial begin
        for (int l = 0; l < `LCD_NUM_LINES; l++) begin
            for (int c = 0; c < `LCD_LINE_LEN; c++)
                image[l][c] = 8'h00;
        end
    end

    // enable width in clock cycles as seen on each rising clock edge
    always @(posedge clk) begin
        if (lcd_en)
            en_cycles = en_cycles + 1;
    end

    always @(posedge lcd_en) begin
        pulse_open = 1'b1;
    end

    // rs and data have to hold still for the whole pulse
    always @(lcd_data or lcd_rs) begin
        if (lcd_en)
            unstable_count = unstable_count + 1;
    end

    ////////////////////////////////////////
    // byte capture on the falling enable
    ////////////////////////////////////////

    always @(negedge lcd_en) begin
        if (pulse_open) begin
            if (byte_count < LOG_DEPTH) begin
                log_rs[byte_count]    = lcd_rs;
                log_data[byte_count]  = lcd_data;
                log_width[byte_count] = en_cycles;
            end
            byte_count = byte_count + 1;
            if (lcd_rs) begin
                if (addr[5:4] == 2'b00)
                    image[addr[6]][addr[3:0]] = lcd_data;
                addr = addr + 7'd1;
            end else if (lcd_data[7]) begin
                addr = lcd_data[6:0];
            end else if (lcd_data == CMD_CLEAR) begin
                for (int l = 0; l < `LCD_NUM_LINES; l++) begin
                    for (int c = 0; c < `LCD_LINE_LEN; c++)
                        image[l][c] = CHAR_SPACE;
                end
                addr = '0;
            end
        end
        pulse_open = 1'b0;
        en_cycles  = 0;
    end

endmodule

// File: testbench/lcd_tb.sv
`include "lcd_config.svh"

module lcd_tb;
    import lcd_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int XFER_CYCLES    = `LCD_SETUP_CYCLES + `LCD_EN_CYCLES + `LCD_WAIT_CYCLES + 2;
    localparam int LINE_BYTES     = `LCD_LINE_LEN + 1;
    localparam int REFRESH_CYCLES = LINE_BYTES * XFER_CYCLES;
    localparam int INIT_CYCLES    = 4 * XFER_CYCLES + `LCD_CLEAR_WAIT_CYCLES;
    localparam int QUIET_CYCLES   = 2 * XFER_CYCLES;
    // twice the worst case of init plus seven line refreshes over all tests
    localparam int LIMIT_CYCLES   =
        2 * (INIT_CYCLES + 7 * REFRESH_CYCLES + 6 * QUIET_CYCLES + 400);

    logic        clk;
    logic        rstN;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [5:0]  wb_adr;
    char_t       wb_dat_w;
    char_t       wb_dat_r;
    logic        wb_ack;
    char_t       lcd_data;
    logic        lcd_rs;
    logic        lcd_en;
    logic        lcd_rw;
    logic        lcd_on;
    logic        lcd_blon;

    int          errors = 0;
    logic [15:0] lfsr_state = 16'd37616;
    char_t       line_img [`LCD_NUM_LINES][`LCD_LINE_LEN];

    lcd_subsystem i_dut (
        .clk, .rstN, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .lcd_data, .lcd_rs, .lcd_en, .lcd_rw, .lcd_on, .lcd_blon
    );

    lcd_panel_model i_panel (.clk, .lcd_data, .lcd_rs, .lcd_en);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    task automatic note_mismatch(input string msg);
        errors++;
        $display("Mismatch at time %0t: %s", $time, msg);
    endtask

    // Galois LFSR with the polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit)
            lfsr_state = lfsr_state ^ 16'hB400;
        return out_bit;
    endfunction

    function automatic char_t random_char();
        char_t ch;
        ch = '0;
        for (int i = 0; i < 8; i++)
            ch = {ch[6:0], lfsr_step()};
        return ch;
    endfunction

    function automatic logic [5:0] char_adr(input int line, input int col);
        return {1'b0, line[0], col[3:0]};
    endfunction

    // the second display line starts at DDRAM address 0x40
    function automatic char_t addr_cmd(input int line);
        return CMD_SET_DDRAM | char_t'(line * 'h40);
    endfunction

    task automatic bus_cycle(input logic we, input logic [5:0] adr, input char_t wdat,
                             output char_t rdat);
        int wait_cycles;
        wait_cycles = 0;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        do begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end while (!wb_ack && wait_cycles < 8);
        if (!wb_ack) begin
            errors++;
            $display("Error at time %0t: no acknowledge for address %h", $time, adr);
        end else begin
            assert (wait_cycles == 1)
                else note_mismatch($sformatf("ack after %0d cycles, expected 1", wait_cycles));
        end
        rdat = wb_dat_r;
        // the write lands on this edge while ack is high
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        assert (!wb_ack) else note_mismatch("ack high for more than one cycle");
    endtask

    task automatic write_reg(input logic [5:0] adr, input char_t dat);
        char_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input logic [5:0] adr, output char_t dat);
        bus_cycle(1'b0, adr, 8'h00, dat);
    endtask

    task automatic wait_for_bytes(input int target);
        int cycles;
        cycles = 0;
        while (i_panel.byte_count < target && cycles < LIMIT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (i_panel.byte_count < target) begin
            errors++;
            $display("Error at time %0t: panel saw %0d bytes, waited for %0d",
                     $time, i_panel.byte_count, target);
        end
    endtask

    // returns once no byte has reached the panel for QUIET_CYCLES cycles
    task automatic wait_until_quiet;
        int last;
        int still;
        last  = i_panel.byte_count;
        still = 0;
        while (still < QUIET_CYCLES) begin
            @(posedge clk);
            if (i_panel.byte_count != last) begin
                last  = i_panel.byte_count;
                still = 0;
            end else begin
                still++;
            end
        end
    endtask

    task automatic check_log_entry(input int idx, input logic rs, input char_t val);
        assert (i_panel.log_rs[idx] === rs && i_panel.log_data[idx] === val)
            else note_mismatch($sformatf("panel byte %0d is rs=%b %h, expected rs=%b %h",
                idx, i_panel.log_rs[idx], i_panel.log_data[idx], rs, val));
    endtask

    task automatic expect_image(input int line);
        for (int c = 0; c < `LCD_LINE_LEN; c++) begin
            assert (i_panel.image[line][c] === line_img[line][c])
                else note_mismatch($sformatf("line %0d col %0d shows %h, expected %h",
                    line, c, i_panel.image[line][c], line_img[line][c]));
        end
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////

    task automatic pins_after_reset;
        assert (lcd_en === 1'b0 && lcd_rw === 1'b0 && lcd_on === 1'b0 && lcd_blon === 1'b0)
            else note_mismatch($sformatf("after reset en=%b rw=%b on=%b blon=%b",
                lcd_en, lcd_rw, lcd_on, lcd_blon));
    endtask

    task automatic status_check(input logic done);
        char_t got;
        read_reg(6'h21, got);
        assert (got === {7'b0, done})
            else note_mismatch($sformatf("status reads %h, expected %h", got, {7'b0, done}));
    endtask

    task automatic init_sequence;
        char_t init_cmds [4];
        int    base;
        init_cmds = '{CMD_FUNCTION_SET, CMD_DISPLAY_ON, CMD_CLEAR, CMD_ENTRY_MODE};
        wait_for_bytes(4 + `LCD_NUM_LINES * LINE_BYTES);
        wait_until_quiet;
        assert (i_panel.byte_count == 4 + `LCD_NUM_LINES * LINE_BYTES)
            else note_mismatch($sformatf("%0d bytes after init", i_panel.byte_count));
        for (int i = 0; i < 4; i++)
            check_log_entry(i, 1'b0, init_cmds[i]);
        for (int l = 0; l < `LCD_NUM_LINES; l++) begin
            base = 4 + l * LINE_BYTES;
            check_log_entry(base, 1'b0, addr_cmd(l));
            for (int c = 0; c < `LCD_LINE_LEN; c++) begin
                check_log_entry(base + 1 + c, 1'b1, CHAR_SPACE);
                line_img[l][c] = CHAR_SPACE;
            end
            expect_image(l);
        end
    endtask

    task automatic string_to_line0;
        string text;
        int    first;
        char_t got;
        text  = "Hello, LCD test!";
        first = i_panel.byte_count;
        for (int c = 0; c < `LCD_LINE_LEN; c++) begin
            line_img[0][c] = text[c];
            write_reg(char_adr(0, c), text[c]);
        end
        wait_for_bytes(first + LINE_BYTES);
        wait_until_quiet;
        // writes that land during a rewrite cause another line 0 rewrite
        assert ((i_panel.byte_count - first) % LINE_BYTES == 0)
            else note_mismatch($sformatf("%0d bytes, not whole line rewrites",
                i_panel.byte_count - first));
        for (int i = first; i < i_panel.byte_count; i += LINE_BYTES)
            check_log_entry(i, 1'b0, addr_cmd(0));
        expect_image(0);
        expect_image(1);
        for (int c = 0; c < `LCD_LINE_LEN; c++) begin
            read_reg(char_adr(0, c), got);
            assert (got === line_img[0][c])
                else note_mismatch($sformatf("col %0d reads %h, expected %h",
                    c, got, line_img[0][c]));
        end
    endtask

    task automatic random_two_lines;
        int    writes_done;
        int    idx;
        char_t ch;
        for (int l = 1; l >= 0; l--) begin
            for (int c = 0; c < `LCD_LINE_LEN; c++) begin
                ch             = random_char();
                line_img[l][c] = ch;
                write_reg(char_adr(l, c), ch);
            end
        end
        writes_done = i_panel.byte_count;
        wait_for_bytes(writes_done + 2 * LINE_BYTES);
        wait_until_quiet;
        // both lines are dirty once the running rewrite ends, so line 0 goes first
        idx = writes_done;
        while (idx < i_panel.byte_count && i_panel.log_rs[idx] !== 1'b0)
            idx++;
        if (idx + LINE_BYTES >= i_panel.byte_count) begin
            errors++;
            $display("Error at time %0t: no line 0 then line 1 rewrite after the writes",
                     $time);
        end else begin
            check_log_entry(idx, 1'b0, addr_cmd(0));
            check_log_entry(idx + LINE_BYTES, 1'b0, addr_cmd(1));
        end
        expect_image(0);
        expect_image(1);
    endtask

    task automatic control_register;
        char_t got;
        int    val;
        for (int v = 1; v <= 4; v++) begin
            val = v % 4;
            write_reg(6'h20, char_t'(val));
            assert (lcd_on === val[0] && lcd_blon === val[1])
                else note_mismatch($sformatf("control %0d gives on=%b blon=%b",
                    val, lcd_on, lcd_blon));
            read_reg(6'h20, got);
            assert (got === char_t'(val))
                else note_mismatch($sformatf("control reads %h, expected %h", got, val));
        end
        read_reg(6'h30, got);
        assert (got === 8'h00) else note_mismatch($sformatf("unmapped read gives %h", got));
    endtask

    task automatic enable_timing;
        assert (i_panel.byte_count > 0) else note_mismatch("no panel transfers seen");
        for (int i = 0; i < i_panel.byte_count && i < i_panel.LOG_DEPTH; i++) begin
            assert (i_panel.log_width[i] == `LCD_EN_CYCLES)
                else note_mismatch($sformatf("byte %0d enable high for %0d cycles",
                    i, i_panel.log_width[i]));
        end
        assert (i_panel.unstable_count == 0)
            else note_mismatch($sformatf("data changed %0d times with enable high",
                i_panel.unstable_count));
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        rstN     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        pins_after_reset;
        status_check(1'b0);
        init_sequence;
        status_check(1'b1);
        string_to_line0;
        random_two_lines;
        control_register;
        enable_timing;
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Error at time %0t: watchdog expired before the tests finished", $time);
        $display("errors: %0d", errors + 1);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/lcd_pkg.sv
hw/lcd_wb_regs.sv
hw/lcd_line_buffer.sv
hw/lcd_refresh_ctrl.sv
hw/lcd_bus_driver.sv
hw/lcd_subsystem.sv
testbench/lcd_panel_model.sv
testbench/lcd_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the LCD testbench with Verilator, runs it and judges the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module lcd_tb -o lcd_sim

./obj_dir/lcd_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
